/* tb.f */
+incdir+src
src/robPkg.sv
src/robBankIf.sv
src/robDispatch.sv
src/robBank.sv
src/robCommit.sv
src/robTop.sv
tests/robTb.sv

/* Bender.yml */
package:
  name: rob

sources:
  - include_dirs:
      - src
    files:
      - src/robPkg.sv
      - src/robBankIf.sv
      - src/robDispatch.sv
      - src/robBank.sv
      - src/robCommit.sv
      - src/robTop.sv
  - target: test
    include_dirs:
      - src
    files:
      - tests/robTb.sv

/* tests/robTb.sv */
`timescale 1ns/100ps
`include "rob_config.svh"

module robTb import robPkg::*; ();

    localparam int totalOps = 1500;
    localparam int timeoutCycles = 4 * totalOps;
    localparam int sqnCount = 1 << `ROB_SQN_BITS;

    logic clk;
    logic rst;
    logic enqValid[`ROB_WIDTH];
    SqN enqSqN[`ROB_WIDTH];
    Tag enqTag[`ROB_WIDTH];
    RegNm enqName[`ROB_WIDTH];
    logic wbValid[`ROB_WB_WIDTH];
    SqN wbSqN[`ROB_WB_WIDTH];
    Flags wbFlags[`ROB_WB_WIDTH];
    logic branchTaken;
    SqN branchSqN;
    logic comValid[`ROB_WIDTH];
    SqN comSqN[`ROB_WIDTH];
    Tag comTag[`ROB_WIDTH];
    RegNm comName[`ROB_WIDTH];
    SqN curSqN;
    SqN maxSqN;
    logic trapValid;
    Flags trapFlags;
    SqN trapSqN;
    logic halt;
    logic fence;

    // Reference state keyed by the full sequence number
    logic mValid[sqnCount];
    logic mDone[sqnCount];
    Flags mFlags[sqnCount];
    Tag mTag[sqnCount];
    RegNm mName[sqnCount];
    SqN mHead;
    SqN nextSqN;
    SqN cand[$];

    // Outputs expected after the most recent edge
    logic expValid[`ROB_WIDTH];
    SqN expSqN[`ROB_WIDTH];
    Tag expTag[`ROB_WIDTH];
    RegNm expName[`ROB_WIDTH];
    logic expTrap;
    Flags expTrapFlags;
    SqN expTrapSqN;
    SqN expHead;

    int unsigned seed;
    int landed;
    int cycles;
    logic checking;
    logic finished;

    robTop DUT (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic int unsigned nextRand(int unsigned range);
        seed = seed * 32'd1664525 + 32'd1013904223;
        return (seed >> 12) % range;
    endfunction

    // Signed wrap distance from the branch
    function automatic logic afterBranch(SqN s, SqN b);
        SqN d;
        d = s - b;
        return $signed(d) > 0;
    endfunction

    function automatic logic modelEmpty();
        for (int k = 0; k < sqnCount; k++) begin
            if (mValid[k]) return 1'b0;
        end
        return 1'b1;
    endfunction

    // In-order retirement rule applied to the model at the head
    function automatic int expectedCommit(output logic trap);
        int cnt;
        SqN s;
        cnt = 0;
        trap = 1'b0;
        s = mHead;
        if (mValid[s] && mDone[s] && mFlags[s] != NONE) begin
            trap = 1'b1;
            return 1;
        end
        while (cnt < `ROB_WIDTH && mValid[s] && mDone[s] && mFlags[s] == NONE) begin
            cnt++;
            s = s + SqN'(1);
        end
        return cnt;
    endfunction

    // One clock edge of the model with the inputs sampled at that edge
    task automatic advanceModel();
        int cnt;
        logic trap;
        SqN s;
        cnt = expectedCommit(trap);
        for (int i = 0; i < `ROB_WIDTH; i++) begin
            s = mHead + SqN'(i);
            expValid[i] = i < cnt;
            expSqN[i] = s;
            expTag[i] = mTag[s];
            expName[i] = mName[s];
        end
        expTrap = trap;
        expTrapFlags = mFlags[mHead];
        expTrapSqN = mHead;
        if (trap && (mFlags[mHead] == BRK || mFlags[mHead] == EXCEPT)) expName[0] = '0;
        if (trap) begin
            // Redirect wipes the buffer and everything written this edge
            for (int k = 0; k < sqnCount; k++) begin
                mValid[k] = 1'b0;
                mDone[k] = 1'b0;
            end
            mHead = mHead + SqN'(1);
            nextSqN = mHead;
        end else begin
            for (int i = 0; i < cnt; i++) mValid[mHead + SqN'(i)] = 1'b0;
            mHead = mHead + SqN'(cnt);
            if (branchTaken) begin
                for (int k = 0; k < sqnCount; k++) begin
                    if (afterBranch(SqN'(k), branchSqN)) mValid[k] = 1'b0;
                end
                nextSqN = branchSqN + SqN'(1);
            end
            for (int p = 0; p < `ROB_WB_WIDTH; p++) begin
                if (wbValid[p] && !(branchTaken && afterBranch(wbSqN[p], branchSqN))) begin
                    mDone[wbSqN[p]] = 1'b1;
                    mFlags[wbSqN[p]] = wbFlags[p];
                end
            end
            for (int i = 0; i < `ROB_WIDTH; i++) begin
                if (enqValid[i] && !branchTaken) begin
                    mValid[enqSqN[i]] = 1'b1;
                    mDone[enqSqN[i]] = 1'b0;
                    mTag[enqSqN[i]] = enqTag[i];
                    mName[enqSqN[i]] = enqName[i];
                    landed++;
                end
            end
        end
        expHead = mHead;
    endtask

    task automatic driveInputs(input logic draining);
        int pick;
        cand.delete();
        for (int k = 0; k < sqnCount; k++) begin
            if (mValid[k] && !mDone[k]) cand.push_back(SqN'(k));
        end
        for (int i = 0; i < `ROB_WIDTH; i++) enqValid[i] <= 1'b0;
        for (int p = 0; p < `ROB_WB_WIDTH; p++) begin
            wbValid[p] <= 1'b0;
            wbFlags[p] <= NONE;
        end
        branchTaken <= 1'b0;
        // Mispredict only on an unresolved entry, so nothing younger retires first
        if (!draining && cand.size() > 0 && nextRand(24) == 0) begin
            pick = nextRand(cand.size());
            branchTaken <= 1'b1;
            branchSqN <= cand[pick];
        end
        for (int p = 0; p < `ROB_WB_WIDTH; p++) begin
            if (cand.size() > 0 && nextRand(4) != 0) begin
                pick = nextRand(cand.size());
                wbValid[p] <= 1'b1;
                wbSqN[p] <= cand[pick];
                if (nextRand(40) == 0) wbFlags[p] <= Flags'(3'(nextRand(4) + 1));
                cand.delete(pick);
            end
        end
        // Enqueues beside a mispredict get dropped and resume after the branch
        if (!draining) begin
            for (int i = 0; i < `ROB_WIDTH; i++) begin
                if (int'(SqN'(nextSqN - mHead)) < `ROB_LENGTH && nextRand(4) != 0) begin
                    enqValid[i] <= 1'b1;
                    enqSqN[i] <= nextSqN;
                    enqTag[i] <= Tag'(nextRand(64));
                    enqName[i] <= RegNm'(nextRand(32));
                    nextSqN = nextSqN + SqN'(1);
                end
            end
        end
    endtask

    task automatic checkValue(string sig, logic [31:0] got, logic [31:0] exp);
        assert (got === exp) else begin
            $display("[FAIL] %0t: %s expected %0d, got %0d", $time, sig, exp, got);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    // Outputs are stable at the falling edge
    always @(negedge clk) begin
        if (checking) begin
            for (int i = 0; i < `ROB_WIDTH; i++) begin
                checkValue($sformatf("comValid[%0d]", i), comValid[i], expValid[i]);
                if (expValid[i]) begin
                    checkValue($sformatf("comSqN[%0d]", i), comSqN[i], expSqN[i]);
                    checkValue($sformatf("comTag[%0d]", i), comTag[i], expTag[i]);
                    checkValue($sformatf("comName[%0d]", i), comName[i], expName[i]);
                end
            end
            checkValue("trapValid", trapValid, expTrap);
            if (expTrap) begin
                checkValue("trapFlags", trapFlags, expTrapFlags);
                checkValue("trapSqN", trapSqN, expTrapSqN);
            end
            checkValue("halt", halt, expTrap && expTrapFlags == BRK);
            checkValue("fence", fence, expTrap && expTrapFlags == FENCE);
            checkValue("curSqN", curSqN, expHead);
            checkValue("maxSqN", maxSqN, SqN'(expHead + SqN'(`ROB_LENGTH - 1)));
        end
    end

    initial begin
        seed = 32'h05d1_9311;
        landed = 0;
        checking = 1'b0;
        finished = 1'b0;
        rst = 1'b1;
        branchTaken = 1'b0;
        branchSqN = '0;
        for (int i = 0; i < `ROB_WIDTH; i++) begin
            enqValid[i] = 1'b0;
            enqSqN[i] = '0;
            enqTag[i] = '0;
            enqName[i] = '0;
            expValid[i] = 1'b0;
        end
        for (int p = 0; p < `ROB_WB_WIDTH; p++) begin
            wbValid[p] = 1'b0;
            wbSqN[p] = '0;
            wbFlags[p] = NONE;
        end
        for (int k = 0; k < sqnCount; k++) begin
            mValid[k] = 1'b0;
            mDone[k] = 1'b0;
            mFlags[k] = NONE;
        end
        mHead = '0;
        nextSqN = '0;
        expTrap = 1'b0;
        expHead = '0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        checking = 1'b1;
        cycles = 0;
        while (!finished) begin
            @(posedge clk);
            advanceModel();
            cycles++;
            if (cycles >= timeoutCycles) begin
                $display("Run stalled: buffer did not drain within %0d cycles", timeoutCycles);
                $display("Test failed");
                $fatal(1);
            end
            if (landed >= totalOps && modelEmpty()) finished = 1'b1;
            driveInputs(landed >= totalOps);
        end
        // Let the last edge be compared
        @(negedge clk);
        @(posedge clk);
        $display("Test passed");
        $finish;
    end

endmodule

/* src/robTop.sv */
`timescale 1ns/100ps
`include "rob_config.svh"

module robTop
    import robPkg::*;
(
    input logic clk,
    input logic rst,

    // Rename side
    input logic enqValid[`ROB_WIDTH],
    input SqN enqSqN[`ROB_WIDTH],
    input Tag enqTag[`ROB_WIDTH],
    input RegNm enqName[`ROB_WIDTH],

    // Execution side
    input logic wbValid[`ROB_WB_WIDTH],
    input SqN wbSqN[`ROB_WB_WIDTH],
    input Flags wbFlags[`ROB_WB_WIDTH],
    input logic branchTaken,
    input SqN branchSqN,

    // Retirement
    output logic comValid[`ROB_WIDTH],
    output SqN comSqN[`ROB_WIDTH],
    output Tag comTag[`ROB_WIDTH],
    output RegNm comName[`ROB_WIDTH],
    output SqN curSqN,
    output SqN maxSqN,
    output logic trapValid,
    output Flags trapFlags,
    output SqN trapSqN,
    output logic halt,
    output logic fence
);

    robBankIf bankIf[`ROB_WIDTH] ();

    robDispatch dispatch (
        .enqValid(enqValid),
        .enqSqN(enqSqN),
        .enqTag(enqTag),
        .enqName(enqName),
        .wbValid(wbValid),
        .wbSqN(wbSqN),
        .wbFlags(wbFlags),
        .branchTaken(branchTaken),
        .branchSqN(branchSqN),
        .banks(bankIf)
    );

    // One bank per commit slot
    for (genvar b = 0; b < `ROB_WIDTH; b++) begin : gBank
        robBank bank (
            .clk(clk),
            .rst(rst),
            .port(bankIf[b])
        );
    end

    robCommit commit (
        .clk(clk),
        .rst(rst),
        .banks(bankIf),
        .comValid(comValid),
        .comSqN(comSqN),
        .comTag(comTag),
        .comName(comName),
        .curSqN(curSqN),
        .maxSqN(maxSqN),
        .trapValid(trapValid),
        .trapFlags(trapFlags),
        .trapSqN(trapSqN),
        .halt(halt),
        .fence(fence)
    );

endmodule

/* src/robCommit.sv */
`timescale 1ns/100ps
`include "rob_config.svh"

module robCommit
    import robPkg::*;
(
    input logic clk,
    input logic rst,
    robBankIf.commit banks[`ROB_WIDTH],
    output logic comValid[`ROB_WIDTH],
    output SqN comSqN[`ROB_WIDTH],
    output Tag comTag[`ROB_WIDTH],
    output RegNm comName[`ROB_WIDTH],
    output SqN curSqN,
    output SqN maxSqN,
    output logic trapValid,
    output Flags trapFlags,
    output SqN trapSqN,
    output logic halt,
    output logic fence
);

    SqN head;
    SqN slotSqN[`ROB_WIDTH];

    // Per-bank head reads
    logic rdValidB[`ROB_WIDTH];
    logic rdExecB[`ROB_WIDTH];
    Flags rdFlagsB[`ROB_WIDTH];
    SqN rdSqNB[`ROB_WIDTH];
    Tag rdTagB[`ROB_WIDTH];
    RegNm rdNameB[`ROB_WIDTH];

    // Same reads in program order
    logic slotReady[`ROB_WIDTH];
    Flags slotFlags[`ROB_WIDTH];
    Tag slotTag[`ROB_WIDTH];
    RegNm slotName[`ROB_WIDTH];

    logic retire[`ROB_WIDTH];
    logic trapNow;
    SqN retireCnt;

    always_comb begin
        for (int i = 0; i < `ROB_WIDTH; i++) begin
            slotSqN[i] = head + SqN'(i);
        end
    end

    for (genvar b = 0; b < `ROB_WIDTH; b++) begin : gBank
        // Exactly one slot of the window lands in each bank
        always_comb begin
            banks[b].rdIdx = '0;
            for (int i = 0; i < `ROB_WIDTH; i++) begin
                if (bankOf(slotSqN[i]) == b) begin
                    banks[b].rdIdx = idxOf(slotSqN[i]);
                end
            end
        end

        always_comb begin
            banks[b].deq = 1'b0;
            for (int i = 0; i < `ROB_WIDTH; i++) begin
                if (bankOf(slotSqN[i]) == b) begin
                    banks[b].deq = retire[i];
                end
            end
        end

        assign banks[b].clear = trapNow;

        assign rdValidB[b] = banks[b].rdValid;
        assign rdExecB[b] = banks[b].rdExecuted;
        assign rdFlagsB[b] = banks[b].rdFlags;
        assign rdSqNB[b] = banks[b].rdSqN;
        assign rdTagB[b] = banks[b].rdTag;
        assign rdNameB[b] = banks[b].rdName;
    end

    always_comb begin
        for (int i = 0; i < `ROB_WIDTH; i++) begin
            // Entry must also belong to this lap of the window
            slotReady[i] = rdValidB[bankOf(slotSqN[i])] && rdExecB[bankOf(slotSqN[i])]
                && rdSqNB[bankOf(slotSqN[i])] == slotSqN[i];
            slotFlags[i] = rdFlagsB[bankOf(slotSqN[i])];
            slotTag[i] = rdTagB[bankOf(slotSqN[i])];
            slotName[i] = rdNameB[bankOf(slotSqN[i])];
        end
    end

    // Longest clean prefix, or a lone flagged head
    always_comb begin : retireSel
        logic stop;
        stop = 1'b0;
        trapNow = 1'b0;
        retireCnt = '0;
        for (int i = 0; i < `ROB_WIDTH; i++) begin
            retire[i] = 1'b0;
        end
        for (int i = 0; i < `ROB_WIDTH; i++) begin
            if (!stop) begin
                if (slotReady[i] && slotFlags[i] == NONE) begin
                    retire[i] = 1'b1;
                    retireCnt = retireCnt + SqN'(1);
                end else begin
                    stop = 1'b1;
                end
            end
        end
        if (slotReady[0] && slotFlags[0] != NONE) begin
            trapNow = 1'b1;
            retire[0] = 1'b1;
            retireCnt = SqN'(1);
        end
    end

    // Control state and pulses
    always_ff @(posedge clk) begin
        if (rst) begin
            head <= '0;
            trapValid <= 1'b0;
            halt <= 1'b0;
            fence <= 1'b0;
            for (int i = 0; i < `ROB_WIDTH; i++) begin
                comValid[i] <= 1'b0;
            end
        end else begin
            head <= head + retireCnt;
            trapValid <= trapNow;
            halt <= trapNow && slotFlags[0] == BRK;
            fence <= trapNow && slotFlags[0] == FENCE;
            for (int i = 0; i < `ROB_WIDTH; i++) begin
                comValid[i] <= retire[i];
            end
        end
    end

    // Commit payload
    always_ff @(posedge clk) begin
        for (int i = 0; i < `ROB_WIDTH; i++) begin
            comSqN[i] <= slotSqN[i];
            comTag[i] <= slotTag[i];
            comName[i] <= slotName[i];
        end
        // No architectural writeback for breakpoints and exceptions
        if (trapNow && (slotFlags[0] == BRK || slotFlags[0] == EXCEPT)) begin
            comName[0] <= '0;
        end
        trapFlags <= slotFlags[0];
        trapSqN <= head;
    end

    assign curSqN = head;
    assign maxSqN = head + SqN'(`ROB_LENGTH - 1);

endmodule

/* src/robBank.sv */
`timescale 1ns/100ps
`include "rob_config.svh"

module robBank
    import robPkg::*;
(
    input logic clk,
    input logic rst,
    robBankIf.bank port
);

    localparam int DEPTH = `ROB_BANK_DEPTH;

    logic [DEPTH-1:0] valid;
    logic [DEPTH-1:0] executed;
    Flags flags[DEPTH];
    SqN sqN[DEPTH];
    Tag tag[DEPTH];
    RegNm name[DEPTH];

    // Entry state
    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= '0;
            executed <= '0;
        end else if (port.clear) begin
            // Redirect from the head wipes everything, including same-cycle writes
            valid <= '0;
            executed <= '0;
        end else begin
            if (port.flushValid) begin
                for (int e = 0; e < DEPTH; e++) begin
                    if (isYounger(sqN[e], port.flushSqN)) begin
                        valid[e] <= 1'b0;
                    end
                end
            end
            if (port.deq) begin
                valid[port.rdIdx] <= 1'b0;
            end
            for (int p = 0; p < `ROB_WB_WIDTH; p++) begin
                if (port.wbValid[p]) begin
                    executed[port.wbIdx[p]] <= 1'b1;
                end
            end
            // Enqueue goes last so a fresh entry wins
            if (port.enqValid) begin
                valid[port.enqIdx] <= 1'b1;
                executed[port.enqIdx] <= 1'b0;
            end
        end
    end

    // Payload fields
    always_ff @(posedge clk) begin
        if (port.enqValid) begin
            sqN[port.enqIdx] <= port.enqSqN;
            tag[port.enqIdx] <= port.enqTag;
            name[port.enqIdx] <= port.enqName;
        end
        for (int p = 0; p < `ROB_WB_WIDTH; p++) begin
            if (port.wbValid[p]) begin
                flags[port.wbIdx[p]] <= port.wbFlags[p];
            end
        end
    end

    // Head read port
    assign port.rdValid = valid[port.rdIdx];
    assign port.rdExecuted = executed[port.rdIdx];
    assign port.rdFlags = flags[port.rdIdx];
    assign port.rdSqN = sqN[port.rdIdx];
    assign port.rdTag = tag[port.rdIdx];
    assign port.rdName = name[port.rdIdx];

endmodule

/* src/robDispatch.sv */
`timescale 1ns/100ps
`include "rob_config.svh"

module robDispatch
    import robPkg::*;
(
    input logic enqValid[`ROB_WIDTH],
    input SqN enqSqN[`ROB_WIDTH],
    input Tag enqTag[`ROB_WIDTH],
    input RegNm enqName[`ROB_WIDTH],
    input logic wbValid[`ROB_WB_WIDTH],
    input SqN wbSqN[`ROB_WB_WIDTH],
    input Flags wbFlags[`ROB_WB_WIDTH],
    input logic branchTaken,
    input SqN branchSqN,
    robBankIf.dispatch banks[`ROB_WIDTH]
);

    logic enqKeep[`ROB_WIDTH];
    logic wbKeep[`ROB_WB_WIDTH];

    // Branch filter, applied once for all banks
    always_comb begin
        for (int i = 0; i < `ROB_WIDTH; i++) begin
            enqKeep[i] = enqValid[i] && !branchTaken;
        end
        for (int p = 0; p < `ROB_WB_WIDTH; p++) begin
            // Results younger than the mispredicted branch are wrong path
            wbKeep[p] = wbValid[p] && !(branchTaken && isYounger(wbSqN[p], branchSqN));
        end
    end

    for (genvar b = 0; b < `ROB_WIDTH; b++) begin : gBank
        // Consecutive slots never share a bank
        always_comb begin
            banks[b].enqValid = 1'b0;
            banks[b].enqIdx = '0;
            banks[b].enqSqN = '0;
            banks[b].enqTag = '0;
            banks[b].enqName = '0;
            for (int i = 0; i < `ROB_WIDTH; i++) begin
                if (enqKeep[i] && bankOf(enqSqN[i]) == b) begin
                    banks[b].enqValid = 1'b1;
                    banks[b].enqIdx = idxOf(enqSqN[i]);
                    banks[b].enqSqN = enqSqN[i];
                    banks[b].enqTag = enqTag[i];
                    banks[b].enqName = enqName[i];
                end
            end
        end

        // Every bank sees all writeback lanes, masked by ownership
        always_comb begin
            for (int p = 0; p < `ROB_WB_WIDTH; p++) begin
                banks[b].wbValid[p] = wbKeep[p] && bankOf(wbSqN[p]) == b;
                banks[b].wbIdx[p] = idxOf(wbSqN[p]);
                banks[b].wbFlags[p] = wbFlags[p];
            end
        end

        assign banks[b].flushValid = branchTaken;
        assign banks[b].flushSqN = branchSqN;
    end

endmodule

/* src/robBankIf.sv */
`timescale 1ns/100ps
`include "rob_config.svh"

interface robBankIf import robPkg::*; ();

    // Enqueue from rename
    logic enqValid;
    BankIdx enqIdx;
    SqN enqSqN;
    Tag enqTag;
    RegNm enqName;

    // Completion, one lane per writeback port
    logic wbValid[`ROB_WB_WIDTH];
    BankIdx wbIdx[`ROB_WB_WIDTH];
    Flags wbFlags[`ROB_WB_WIDTH];

    // Mispredict flush
    logic flushValid;
    SqN flushSqN;

    // Head access from the commit unit
    BankIdx rdIdx;
    logic deq;
    logic clear;
    logic rdValid;
    logic rdExecuted;
    Flags rdFlags;
    SqN rdSqN;
    Tag rdTag;
    RegNm rdName;

    modport dispatch (
        output enqValid, enqIdx, enqSqN, enqTag, enqName,
        output wbValid, wbIdx, wbFlags,
        output flushValid, flushSqN
    );

    modport bank (
        input enqValid, enqIdx, enqSqN, enqTag, enqName,
        input wbValid, wbIdx, wbFlags,
        input flushValid, flushSqN,
        input rdIdx, deq, clear,
        output rdValid, rdExecuted, rdFlags, rdSqN, rdTag, rdName
    );

    modport commit (
        output rdIdx, deq, clear,
        input rdValid, rdExecuted, rdFlags, rdSqN, rdTag, rdName
    );

endinterface

/* src/robPkg.sv */
`include "rob_config.svh"

package robPkg;

    // Sequence number carries one wrap bit above the entry index
    typedef logic [`ROB_SQN_BITS-1:0] SqN;
    typedef logic [`ROB_TAG_BITS-1:0] Tag;
    typedef logic [`ROB_NAME_BITS-1:0] RegNm;
    typedef logic [`ROB_IDX_BITS-1:0] BankIdx;

    typedef enum logic [2:0] {
        NONE,
        BRK,
        TRAP,
        EXCEPT,
        FENCE
    } Flags;

    // Bank that owns a sequence number
    function automatic int unsigned bankOf(SqN s);
        return int'(s) % `ROB_WIDTH;
    endfunction

    // Entry inside the owning bank
    function automatic BankIdx idxOf(SqN s);
        return BankIdx'((int'(s) / `ROB_WIDTH) % `ROB_BANK_DEPTH);
    endfunction

    // True when a is younger than b, by signed wrap distance
    function automatic logic isYounger(SqN a, SqN b);
        SqN diff;
        diff = a - b;
        return $signed(diff) > 0;
    endfunction

endpackage

/* src/rob_config.svh */
`ifndef ROB_CONFIG_SVH
`define ROB_CONFIG_SVH

// Total reorder buffer entries
`define ROB_LENGTH 16
// Enqueue and commit slots per cycle, also the bank count
`define ROB_WIDTH 2
// Writeback ports from the execution units
`define ROB_WB_WIDTH 2

// Field widths
`define ROB_SQN_BITS 5
`define ROB_TAG_BITS 6
`define ROB_NAME_BITS 5

// Derived bank geometry
`define ROB_BANK_DEPTH (`ROB_LENGTH / `ROB_WIDTH)
`define ROB_IDX_BITS $clog2(`ROB_BANK_DEPTH)

`endif
